//--- sources.f
verilog/mem_pkg.sv
verilog/mem_bus_if.sv
verilog/mem_port.sv
verilog/mem_arbiter.sv
verilog/sram_model.sv
verilog/mem_subsys_top.sv
test/tb_clock_gen.sv
test/tb_mem_subsys.sv

//--- test/tb_mem_subsys.sv
module tb_mem_subsys;
	timeunit 1ns;
	timeprecision 100ps;
	import mem_pkg::*;

	localparam int MEM_DEPTH = 256;
	// 2 + 12 + 3 + 4 + 216 + 2 transfers
	localparam int N_XFER = 239;
	localparam int CYCLE_LIMIT = N_XFER * 40 + 100;

	logic              clk;
	logic              rst;
	logic              fetch_req;
	logic [ADDR_W-1:0] fetch_addr;
	logic              fetch_done;
	mem_data_t         fetch_data;
	logic              data_req;
	logic              data_we;
	logic [ADDR_W-1:0] data_addr;
	mem_data_t         data_wdata;
	logic [STRB_W-1:0] data_wstrb;
	logic              data_done;
	mem_data_t         data_rdata;

	// reference memory keyed by word index
	mem_data_t         ref_mem [int unsigned];
	// expected replies in issue order with one queue per port
	mem_data_t         data_exp_q[$];
	string             data_name_q[$];
	mem_data_t         fetch_exp_q[$];
	string             fetch_name_q[$];

	logic [31:0]       rng = 32'ha94b;
	int                cycle = 0;
	int                strobe_cyc;
	int                data_done_cyc;
	int                fetch_done_cyc;
	int                errors = 0;
	int                test_err_base;
	int                pass_count = 0;
	int                fail_count = 0;

	tb_clock_gen u_clk (
		.clk (clk),
		.rst (rst)
	);

	mem_subsys_top #(.MEM_DEPTH(MEM_DEPTH)) u_dut (
		.clk        (clk),
		.rst        (rst),
		.fetch_req  (fetch_req),
		.fetch_addr (fetch_addr),
		.fetch_done (fetch_done),
		.fetch_data (fetch_data),
		.data_req   (data_req),
		.data_we    (data_we),
		.data_addr  (data_addr),
		.data_wdata (data_wdata),
		.data_wstrb (data_wstrb),
		.data_done  (data_done),
		.data_rdata (data_rdata)
	);

	// ****************************************
	// random numbers
	// ****************************************
	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic logic [31:0] draw();
		rng = xorshift32(rng);
		return rng;
	endfunction

	function automatic mem_data_t rand64();
		logic [31:0] hi;
		logic [31:0] lo;
		hi = draw();
		lo = draw();
		return {hi, lo};
	endfunction

	// write strobe never empty
	function automatic logic [STRB_W-1:0] rand_strobe();
		logic [31:0] r;
		r = draw();
		return (r[7:0] == 8'h00) ? 8'h01 : r[7:0];
	endfunction

	// 16 words each seen through four aliases of the depth
	function automatic logic [ADDR_W-1:0] mix_addr(input logic [31:0] r);
		int unsigned word;
		word = (r % 16) + ((r >> 8) % 4) * MEM_DEPTH;
		return ADDR_W'(word * 8 + ((r >> 16) % 8));
	endfunction

	// ****************************************
	// reference model
	// ****************************************
	// low three bits pick a byte inside the word
	function automatic int unsigned word_index(input logic [ADDR_W-1:0] addr);
		return (addr >> 3) % MEM_DEPTH;
	endfunction

	// unknown until first written
	function automatic mem_data_t ref_read(input logic [ADDR_W-1:0] addr);
		if (ref_mem.exists(word_index(addr)))
			return ref_mem[word_index(addr)];
		return 'x;
	endfunction

	function automatic void ref_write(input logic [ADDR_W-1:0] addr,
			input mem_data_t wdata, input logic [STRB_W-1:0] wstrb);
		mem_data_t word;
		word = ref_read(addr);
		// lane i follows strobe bit i
		for (int i = 0; i < STRB_W; i++) begin
			if (wstrb[i])
				word[i*8 +: 8] = wdata[i*8 +: 8];
		end
		ref_mem[word_index(addr)] = word;
	endfunction

	// ****************************************
	// compare tasks
	// ****************************************
	// an unknown expected word was never written and is skipped
	task automatic check_data(input string name, input mem_data_t exp, input mem_data_t act);
		if (!$isunknown(exp) && act !== exp) begin
			$display("FAILED %s (data): expected %h, actual %h", name, exp, act);
			errors++;
		end
	endtask

	task automatic check_fetch(input string name, input mem_data_t exp, input mem_data_t act);
		if (!$isunknown(exp) && act !== exp) begin
			$display("FAILED %s (fetch): expected %h, actual %h", name, exp, act);
			errors++;
		end
	endtask

	task automatic check_latency(input string name, input int exp, input int act);
		if (act != exp) begin
			$display("FAILED %s (latency): expected %0d, actual %0d", name, exp, act);
			errors++;
		end
	endtask

	task automatic check_order(input string name);
		if (data_done_cyc >= fetch_done_cyc) begin
			$display("%s: fetch done did not come after data done", name);
			errors++;
		end
	endtask

	// ****************************************
	// compare process samples settled outputs at the falling edge
	// ****************************************
	always @(negedge clk) begin
		if (!rst && data_done) begin
			data_done_cyc = cycle;
			if (data_exp_q.size() == 0) begin
				$display("data done strobe arrived with no request outstanding");
				errors++;
			end else begin
				check_data(data_name_q.pop_front(), data_exp_q.pop_front(), data_rdata);
			end
		end
		if (!rst && fetch_done) begin
			fetch_done_cyc = cycle;
			if (fetch_exp_q.size() == 0) begin
				$display("fetch done strobe arrived with no request outstanding");
				errors++;
			end else begin
				check_fetch(fetch_name_q.pop_front(), fetch_exp_q.pop_front(), fetch_data);
			end
		end
	end

	// run limit
	always @(posedge clk) begin
		cycle <= cycle + 1;
		if (cycle >= CYCLE_LIMIT) begin
			$display("run stopped after %0d cycles, transfers did not complete", CYCLE_LIMIT);
			$display("SOME TESTS FAILED");
			$finish;
		end
	end

	// ****************************************
	// stimulus
	// ****************************************
	// same-cycle strobes go data first so fetch sees the data write
	task automatic issue_transfer(input string name,
			input bit do_fetch, input logic [ADDR_W-1:0] f_addr,
			input bit do_data, input logic we, input logic [ADDR_W-1:0] d_addr,
			input mem_data_t wdata, input logic [STRB_W-1:0] wstrb);
		int waited;
		if (do_data) begin
			// a write returns the old word
			data_exp_q.push_back(ref_read(d_addr));
			data_name_q.push_back(name);
			if (we)
				ref_write(d_addr, wdata, wstrb);
		end
		if (do_fetch) begin
			fetch_exp_q.push_back(ref_read(f_addr));
			fetch_name_q.push_back(name);
		end
		@(posedge clk);
		fetch_req  <= do_fetch;
		fetch_addr <= f_addr;
		data_req   <= do_data;
		data_we    <= we;
		data_addr  <= d_addr;
		data_wdata <= wdata;
		data_wstrb <= wstrb;
		@(negedge clk);
		strobe_cyc = cycle;
		@(posedge clk);
		fetch_req <= 1'b0;
		data_req  <= 1'b0;
		// wait for every expected done
		waited = 0;
		while ((data_exp_q.size() != 0 || fetch_exp_q.size() != 0) && waited < 20) begin
			@(posedge clk);
			waited++;
		end
		if (data_exp_q.size() != 0 || fetch_exp_q.size() != 0) begin
			$display("%s: done strobe never arrived within 20 cycles", name);
			errors++;
			data_exp_q.delete();
			data_name_q.delete();
			fetch_exp_q.delete();
			fetch_name_q.delete();
		end
	endtask

	task automatic start_test();
		test_err_base = errors;
	endtask

	task automatic finish_test(input string name);
		if (errors == test_err_base) begin
			$display("test %s: ok", name);
			pass_count++;
		end else begin
			$display("test %s: %0d errors", name, errors - test_err_base);
			fail_count++;
		end
	endtask

	initial begin
		int                n;
		int                mode;
		logic [31:0]       r;
		logic [ADDR_W-1:0] fa;
		logic [ADDR_W-1:0] da;
		mem_data_t         w;
		logic [STRB_W-1:0] s;
		fetch_req  <= 1'b0;
		fetch_addr <= '0;
		data_req   <= 1'b0;
		data_we    <= 1'b0;
		data_addr  <= '0;
		data_wdata <= '0;
		data_wstrb <= '0;
		do @(posedge clk); while (rst);

		// full word write then uncontended read
		start_test();
		issue_transfer("full_word", 1'b0, '0, 1'b1, 1'b1, ADDR_W'(20 * 8),
			64'h0123_4567_89ab_cdef, 8'hff);
		issue_transfer("full_word", 1'b0, '0, 1'b1, 1'b0, ADDR_W'(20 * 8), '0, '0);
		check_latency("full_word", 3, data_done_cyc - strobe_cyc);
		finish_test("full_word");

		// byte lanes merge into a known word
		start_test();
		for (int k = 21; k <= 22; k++) begin
			issue_transfer("byte_strobe", 1'b0, '0, 1'b1, 1'b1, ADDR_W'(k * 8), rand64(), 8'hff);
			repeat (4) begin
				w = rand64();
				s = rand_strobe();
				issue_transfer("byte_strobe", 1'b0, '0, 1'b1, 1'b1, ADDR_W'(k * 8), w, s);
			end
			issue_transfer("byte_strobe", 1'b0, '0, 1'b1, 1'b0, ADDR_W'(k * 8), '0, '0);
		end
		finish_test("byte_strobe");

		// fetch reads and a fetch beside write-looking store lines leaves memory alone
		start_test();
		issue_transfer("fetch_read", 1'b1, ADDR_W'(21 * 8), 1'b0, 1'b0, '0, '0, '0);
		issue_transfer("fetch_read", 1'b1, ADDR_W'(22 * 8), 1'b0, 1'b1, ADDR_W'(22 * 8),
			rand64(), 8'hff);
		issue_transfer("fetch_read", 1'b0, '0, 1'b1, 1'b0, ADDR_W'(22 * 8), '0, '0);
		finish_test("fetch_read");

		// both strobes in one cycle
		start_test();
		issue_transfer("simultaneous", 1'b1, ADDR_W'(21 * 8), 1'b1, 1'b0, ADDR_W'(20 * 8), '0, '0);
		check_order("simultaneous");
		issue_transfer("simultaneous", 1'b1, ADDR_W'(23 * 8), 1'b1, 1'b1, ADDR_W'(23 * 8),
			rand64(), 8'hff);
		check_order("simultaneous");
		finish_test("simultaneous");

		// seed words 0..15 and then run a random mix over their aliases
		start_test();
		for (int k = 0; k < 16; k++)
			issue_transfer("random_mix", 1'b0, '0, 1'b1, 1'b1, ADDR_W'(k * 8), rand64(), 8'hff);
		n = 0;
		while (n < 200) begin
			// 0 data only, 1 fetch only, 2 both
			mode = draw() % 3;
			if (mode == 2 && n == 199)
				mode = 0;
			fa = mix_addr(draw());
			da = mix_addr(draw());
			w  = rand64();
			s  = rand_strobe();
			r  = draw();
			issue_transfer("random_mix", mode != 0, fa, mode != 1, r[0], da, w, s);
			n += (mode == 2) ? 2 : 1;
		end
		finish_test("random_mix");

		// write done carries the previous contents
		start_test();
		issue_transfer("old_word", 1'b0, '0, 1'b1, 1'b1, ADDR_W'(20 * 8),
			64'hfeed_face_cafe_f00d, 8'hff);
		issue_transfer("old_word", 1'b0, '0, 1'b1, 1'b1, ADDR_W'(20 * 8),
			64'h1111_2222_3333_4444, 8'h0f);
		finish_test("old_word");

		$display("summary: %0d tests passed, %0d tests failed", pass_count, fail_count);
		if (fail_count == 0 && errors == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

endmodule

//--- test/tb_clock_gen.sv
module tb_clock_gen (
	output logic clk,
	output logic rst
);
	timeunit 1ns;
	timeprecision 100ps;

	// 10 ns period
	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// reset held over the first 8 rising edges
	initial begin
		rst = 1'b1;
		repeat (8) @(posedge clk);
		rst <= 1'b0;
	end

endmodule

//--- verilog/mem_subsys_top.sv
module mem_subsys_top #(
	parameter int MEM_DEPTH = 256
) (
	input  logic                        clk,
	input  logic                        rst,
	// instruction fetch side
	input  logic                        fetch_req,
	input  logic [mem_pkg::ADDR_W-1:0]  fetch_addr,
	output logic                        fetch_done,
	output mem_pkg::mem_data_t          fetch_data,
	// load/store side
	input  logic                        data_req,
	input  logic                        data_we,
	input  logic [mem_pkg::ADDR_W-1:0]  data_addr,
	input  mem_pkg::mem_data_t          data_wdata,
	input  logic [mem_pkg::STRB_W-1:0]  data_wstrb,
	output logic                        data_done,
	output mem_pkg::mem_data_t          data_rdata
);
	import mem_pkg::*;

	// sram lines
	logic              sram_en;
	logic              sram_we;
	logic [ADDR_W-1:0] sram_addr;
	mem_data_t         sram_wdata;
	logic [STRB_W-1:0] sram_wstrb;
	mem_data_t         sram_rdata;

	// ****************************************
	// port buses
	// ****************************************
	mem_bus_if fetch_bus ();
	mem_bus_if data_bus ();

	// fetch port sees the store lines too
	// WRITE_EN low keeps them out of memory
	mem_port #(.WRITE_EN(1'b0)) u_fetch_port (
		.clk    (clk),
		.rst    (rst),
		.strobe (fetch_req),
		.we     (data_we),
		.addr   (fetch_addr),
		.wdata  (data_wdata),
		.wstrb  (data_wstrb),
		.bus    (fetch_bus),
		.done   (fetch_done),
		.rdata  (fetch_data)
	);

	mem_port #(.WRITE_EN(1'b1)) u_data_port (
		.clk    (clk),
		.rst    (rst),
		.strobe (data_req),
		.we     (data_we),
		.addr   (data_addr),
		.wdata  (data_wdata),
		.wstrb  (data_wstrb),
		.bus    (data_bus),
		.done   (data_done),
		.rdata  (data_rdata)
	);

	// ****************************************
	// arbiter and memory
	// ****************************************
	mem_arbiter u_arbiter (
		.clk        (clk),
		.rst        (rst),
		.fetch      (fetch_bus),
		.data       (data_bus),
		.sram_en    (sram_en),
		.sram_we    (sram_we),
		.sram_addr  (sram_addr),
		.sram_wdata (sram_wdata),
		.sram_wstrb (sram_wstrb),
		.sram_rdata (sram_rdata)
	);

	sram_model #(.DEPTH(MEM_DEPTH)) u_sram (
		.clk   (clk),
		.en    (sram_en),
		.we    (sram_we),
		.addr  (sram_addr),
		.wdata (sram_wdata),
		.wstrb (sram_wstrb),
		.rdata (sram_rdata)
	);

endmodule

//--- verilog/sram_model.sv
module sram_model #(
	parameter int DEPTH = 256
) (
	input  logic                        clk,
	input  logic                        en,
	input  logic                        we,
	// byte address with the low three bits ignored
	input  logic [mem_pkg::ADDR_W-1:0]  addr,
	input  mem_pkg::mem_data_t          wdata,
	input  logic [mem_pkg::STRB_W-1:0]  wstrb,
	output mem_pkg::mem_data_t          rdata
);
	import mem_pkg::*;

	// index width of at least one bit
	localparam int IDX_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

	mem_data_t                  mem [DEPTH];
	logic [ADDR_W-4:0]          word_addr;
	logic [IDX_W-1:0]           idx;

	// ****************************************
	// addressing
	// ****************************************
	// word index wraps modulo depth
	assign word_addr = addr[ADDR_W-1:3];
	assign idx       = IDX_W'(word_addr % DEPTH);

	// ****************************************
	// read port
	// ****************************************
	// old word comes out even on a write cycle
	always_ff @(posedge clk) begin
		if (en) begin
			rdata <= mem[idx];
		end
	end

	// ****************************************
	// write port with one lane per strobe bit
	// ****************************************
	always_ff @(posedge clk) begin
		if (en && we) begin
			for (int i = 0; i < STRB_W; i++) begin
				if (wstrb[i]) begin
					mem[idx][i*8 +: 8] <= wdata[i*8 +: 8];
				end
			end
		end
	end

	// write with no lane set does nothing useful
	a_write_has_lanes: assert property (
		@(posedge clk)
		(en && we) |-> (wstrb != '0)
	) else $warning("sram_model: write with empty byte strobe");

endmodule

//--- verilog/mem_arbiter.sv
module mem_arbiter (
	input  logic                        clk,
	input  logic                        rst,
	// the two requesters
	mem_bus_if.arbiter                  fetch,
	mem_bus_if.arbiter                  data,
	// single-port sram
	output logic                        sram_en,
	output logic                        sram_we,
	output logic [mem_pkg::ADDR_W-1:0]  sram_addr,
	output mem_pkg::mem_data_t          sram_wdata,
	output logic [mem_pkg::STRB_W-1:0]  sram_wstrb,
	input  mem_pkg::mem_data_t          sram_rdata
);
	import mem_pkg::*;

	typedef enum logic {
		ST_IDLE = 1'b0,
		ST_BUSY = 1'b1
	} state_t;

	state_t    state_q;
	grant_t    win;
	grant_t    sel_q;
	mem_req_t  win_req;
	logic      issue;
	logic      issue_q;
	logic      done_q;
	mem_data_t rdata_q;

	// ****************************************
	// selection
	// ****************************************
	// data port has priority over fetch
	assign win     = data.pending ? GRANT_DATA : GRANT_FETCH;
	assign win_req = (win == GRANT_DATA) ? data.req : fetch.req;
	// grant in the same cycle the request is seen
	assign issue   = (state_q == ST_IDLE) & (fetch.pending | data.pending);

	assign data.grant  = issue & (win == GRANT_DATA);
	assign fetch.grant = issue & (win == GRANT_FETCH);

	// sram strobe lines only live with issue
	assign sram_en    = issue;
	assign sram_we    = issue & win_req.we;
	assign sram_addr  = win_req.addr;
	assign sram_wdata = win_req.wdata;
	assign sram_wstrb = win_req.wstrb;

	// ****************************************
	// transfer sequencing
	// ****************************************
	// issue at N, sram data at N+1, done at N+2
	// back to idle at N+3
	always_ff @(posedge clk) begin
		if (rst) begin
			state_q <= ST_IDLE;
			issue_q <= 1'b0;
			done_q  <= 1'b0;
		end else begin
			issue_q <= issue;
			done_q  <= issue_q;
			case (state_q)
				ST_IDLE: if (issue) state_q <= ST_BUSY;
				ST_BUSY: if (done_q) state_q <= ST_IDLE;
				default: state_q <= ST_IDLE;
			endcase
		end
	end

	// winner and returned word
	always_ff @(posedge clk) begin
		if (issue) sel_q <= win;
		if (issue_q) rdata_q <= sram_rdata;
	end

	// reply only towards the served port
	assign data.done   = done_q & (sel_q == GRANT_DATA);
	assign fetch.done  = done_q & (sel_q == GRANT_FETCH);
	assign data.rdata  = (sel_q == GRANT_DATA) ? rdata_q : '0;
	assign fetch.rdata = (sel_q == GRANT_FETCH) ? rdata_q : '0;

	// ****************************************
	// checks
	// ****************************************
	a_grant_onehot0: assert property (
		@(posedge clk) disable iff (rst)
		$onehot0({fetch.grant, data.grant})
	) else $error("mem_arbiter: both ports granted at once");

	a_done_single: assert property (
		@(posedge clk) disable iff (rst)
		!(fetch.done && data.done)
	) else $error("mem_arbiter: done on both buses at once");

endmodule

//--- verilog/mem_port.sv
module mem_port #(
	parameter bit WRITE_EN = 1'b1
) (
	input  logic                        clk,
	input  logic                        rst,
	// pipeline side, single-cycle strobe
	input  logic                        strobe,
	input  logic                        we,
	input  logic [mem_pkg::ADDR_W-1:0]  addr,
	input  mem_pkg::mem_data_t          wdata,
	input  logic [mem_pkg::STRB_W-1:0]  wstrb,
	// towards the arbiter
	mem_bus_if.requester                bus,
	// back to the pipeline
	output logic                        done,
	output mem_pkg::mem_data_t          rdata
);
	import mem_pkg::*;

	logic     pending_q;
	mem_req_t req_q;

	// ****************************************
	// pending flag
	// ****************************************
	// set one cycle after the strobe
	// cleared in the cycle after grant
	always_ff @(posedge clk) begin
		if (rst) begin
			pending_q <= 1'b0;
		end else if (strobe) begin
			pending_q <= 1'b1;
		end else if (bus.grant) begin
			pending_q <= 1'b0;
		end
	end

	// ****************************************
	// request capture
	// ****************************************
	always_ff @(posedge clk) begin
		if (strobe) begin
			req_q.addr  <= addr;
			// fetch instance is read-only, write flag forced low
			req_q.we    <= we & WRITE_EN;
			req_q.wdata <= wdata;
			req_q.wstrb <= wstrb;
		end
	end

	assign bus.pending = pending_q;
	assign bus.req     = req_q;

	// reply goes straight back, no extra stage
	assign done  = bus.done;
	assign rdata = bus.rdata;

	// ****************************************
	// protocol checks
	// ****************************************
	// requester must wait, no back-pressure here
	a_no_strobe_while_pending: assert property (
		@(posedge clk) disable iff (rst)
		strobe |-> !pending_q
	) else $error("mem_port: strobe while a request is still pending");

	// arbiter only grants what this port offered
	a_no_grant_without_pending: assert property (
		@(posedge clk) disable iff (rst)
		bus.grant |-> pending_q
	) else $error("mem_port: grant seen with no pending request");

endmodule

//--- verilog/mem_bus_if.sv
interface mem_bus_if;
	import mem_pkg::*;

	// request side
	// high from capture until grant
	logic      pending;
	// held stable while pending
	mem_req_t  req;

	// arbiter side
	// one-cycle pulse, request taken
	logic      grant;
	// one-cycle pulse, transfer finished
	logic      done;
	// valid with done only
	mem_data_t rdata;

	// port holding the request
	modport requester (
		output pending,
		output req,
		input  grant,
		input  done,
		input  rdata
	);

	// shared memory arbiter
	modport arbiter (
		input  pending,
		input  req,
		output grant,
		output done,
		output rdata
	);

endinterface

//--- verilog/mem_pkg.sv
package mem_pkg;

	// ****************************************
	// bus widths
	// ****************************************
	// byte address
	parameter int ADDR_W = 32;
	// one rv64 word
	parameter int DATA_W = 64;
	// one strobe bit per byte lane
	parameter int STRB_W = DATA_W / 8;

	// read data, same shape everywhere
	typedef logic [DATA_W-1:0] mem_data_t;

	// one request as held by a port
	typedef struct packed {
		logic [ADDR_W-1:0] addr;
		logic              we;
		mem_data_t         wdata;
		logic [STRB_W-1:0] wstrb;
	} mem_req_t;

	// which port the arbiter is serving
	typedef enum logic {
		GRANT_FETCH = 1'b0,
		GRANT_DATA  = 1'b1
	} grant_t;

endpackage
